// File: source/soc_pkg.sv
package soc_pkg;

	//============================================================
	// Bus types
	//============================================================

	// Byte address
	typedef logic [31:0] bus_addr_t;

	// Read and write data
	typedef logic [31:0] bus_data_t;

	// Red LED pattern
	typedef logic [9:0] led_t;

	// Arbiter ownership of the shared bus
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PORT_A,
		ARB_PORT_B
	} arb_state_t;

	//============================================================
	// Memory map
	//============================================================

	localparam bus_addr_t RAM_BASE   = 32'h0001_0000;
	localparam bus_addr_t RAM_LIMIT  = 32'h0002_0000;
	localparam bus_addr_t LED_BASE   = 32'h5000_0000;
	localparam bus_addr_t LED_LIMIT  = 32'h5000_0010;
	// Timer takes everything from here up
	localparam bus_addr_t TIMER_BASE = 32'h6000_0000;

endpackage

// File: source/soc_bus_if.sv
`timescale 1ns/1ps

interface soc_bus_if
	import soc_pkg::*;
();

	// Command, held by the master until ready
	logic      request;
	logic      rw;
	bus_addr_t address;
	bus_data_t wdata;

	// Response, rdata valid while ready is high on a read
	bus_data_t rdata;
	logic      ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

// File: source/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
	import soc_pkg::*;
(
	input  logic      clock,
	input  logic      i_reset,

	// Port A, instruction fetch, read only
	input  logic      i_pa_request,
	input  bus_addr_t i_pa_address,
	output bus_data_t o_pa_rdata,
	output logic      o_pa_ready,

	// Port B, data
	input  logic      i_pb_request,
	input  logic      i_pb_rw,
	input  bus_addr_t i_pb_address,
	input  bus_data_t i_pb_wdata,
	output bus_data_t o_pb_rdata,
	output logic      o_pb_ready,

	soc_bus_if.master bus
);

	arb_state_t state;
	logic       last_b;
	logic       pa_pending;
	logic       pb_pending;
	logic       grant_b;
	logic       start;

	// Port still holding request during its own ready pulse is done, not new
	assign pa_pending = i_pa_request && !o_pa_ready;
	assign pb_pending = i_pb_request && !o_pb_ready;

	// On a tie the port not granted last time wins
	assign grant_b = pb_pending && (!pa_pending || !last_b);
	assign start   = (state == ARB_IDLE) && (pa_pending || pb_pending);

	//============================================================
	// Ownership FSM
	//============================================================

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			state       <= ARB_IDLE;
			last_b      <= 1'b0;
			bus.request <= 1'b0;
			o_pa_ready  <= 1'b0;
			o_pb_ready  <= 1'b0;
		end
		else
		begin
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
			case (state)
				ARB_IDLE:
				begin
					if (start)
					begin
						bus.request <= 1'b1;
						last_b      <= grant_b;
						state       <= grant_b ? ARB_PORT_B : ARB_PORT_A;
					end
				end
				ARB_PORT_A:
				begin
					if (bus.ready)
					begin
						bus.request <= 1'b0;
						o_pa_ready  <= 1'b1;
						state       <= ARB_IDLE;
					end
				end
				ARB_PORT_B:
				begin
					if (bus.ready)
					begin
						bus.request <= 1'b0;
						o_pb_ready  <= 1'b1;
						state       <= ARB_IDLE;
					end
				end
				default:
				begin
					bus.request <= 1'b0;
					state       <= ARB_IDLE;
				end
			endcase
		end
	end

	//============================================================
	// Command latch and read data return
	//============================================================

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			// Port A only ever reads
			bus.rw      <= grant_b ? i_pb_rw : 1'b0;
			bus.address <= grant_b ? i_pb_address : i_pa_address;
			bus.wdata   <= i_pb_wdata;
		end
		if (bus.ready && state == ARB_PORT_A)
			o_pa_rdata <= bus.rdata;
		if (bus.ready && state == ARB_PORT_B)
			o_pb_rdata <= bus.rdata;
	end

endmodule

// File: source/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
	import soc_pkg::*;
(
	soc_bus_if.slave  bus,
	soc_bus_if.master ram_bus,
	soc_bus_if.master led_bus,
	soc_bus_if.master timer_bus
);

	logic ram_sel;
	logic led_sel;
	logic timer_sel;

	// Address ranges are disjoint, so at most one select is high
	assign ram_sel   = (bus.address >= RAM_BASE) && (bus.address < RAM_LIMIT);
	assign led_sel   = (bus.address >= LED_BASE) && (bus.address < LED_LIMIT);
	assign timer_sel = (bus.address >= TIMER_BASE);

	//============================================================
	// Forward path, rebased per target
	//============================================================

	assign ram_bus.request = bus.request && ram_sel;
	assign ram_bus.rw      = bus.rw;
	assign ram_bus.address = bus.address - RAM_BASE;
	assign ram_bus.wdata   = bus.wdata;

	assign led_bus.request = bus.request && led_sel;
	assign led_bus.rw      = bus.rw;
	assign led_bus.address = bus.address - LED_BASE;
	assign led_bus.wdata   = bus.wdata;

	assign timer_bus.request = bus.request && timer_sel;
	assign timer_bus.rw      = bus.rw;
	assign timer_bus.address = bus.address - TIMER_BASE;
	assign timer_bus.wdata   = bus.wdata;

	//============================================================
	// Return path
	//============================================================

	always_comb
	begin
		if (ram_sel)
		begin
			bus.rdata = ram_bus.rdata;
			bus.ready = ram_bus.ready;
		end
		else if (led_sel)
		begin
			bus.rdata = led_bus.rdata;
			bus.ready = led_bus.ready;
		end
		else if (timer_sel)
		begin
			bus.rdata = timer_bus.rdata;
			bus.ready = timer_bus.ready;
		end
		else
		begin
			// Nothing mapped here, finish at once so the master never hangs
			bus.rdata = '0;
			bus.ready = bus.request;
		end
	end

endmodule

// File: source/block_ram.sv
`timescale 1ns/1ps

module block_ram
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 16384
)
(
	input  logic     clock,
	soc_bus_if.slave bus
);

	localparam int INDEX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	bus_data_t            mem [RAM_WORDS];
	bus_data_t            rdata_q;
	logic                 ready_q;
	logic [INDEX_W-1:0]   index;

	// Word index from the rebased byte address
	assign index = bus.address[2 +: INDEX_W];

	always_ff @(posedge clock)
	begin
		if (bus.request)
		begin
			if (bus.rw)
				mem[index] <= bus.wdata;
			else
				rdata_q <= mem[index];
		end
	end

	// One cycle latency; low again after the pulse so a held request
	// is not answered twice
	always_ff @(posedge clock)
	begin
		ready_q <= bus.request && !ready_q;
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

endmodule

// File: source/led_register.sv
`timescale 1ns/1ps

module led_register
	import soc_pkg::*;
(
	input  logic     clock,
	input  logic     i_reset,
	soc_bus_if.slave bus,
	output led_t     o_ledr
);

	led_t ledr_q;

	always_ff @(posedge clock)
	begin
		if (i_reset)
			ledr_q <= '0;
		else if (bus.request && bus.rw)
			ledr_q <= bus.wdata[9:0];
	end

	// Read back zero-extended, answered in the same cycle
	assign bus.rdata = bus_data_t'(ledr_q);
	assign bus.ready = bus.request;

	assign o_ledr = ledr_q;

endmodule

// File: source/cycle_timer.sv
`timescale 1ns/1ps

module cycle_timer
	import soc_pkg::*;
#(
	parameter int TICKS_PER_MS = 100000
)
(
	input  logic     clock,
	input  logic     i_reset,
	soc_bus_if.slave bus
);

	localparam int PRE_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_MS - 1);

	bus_data_t          cycle_count;
	bus_data_t          ms_count;
	logic [PRE_W-1:0]   prescale;

	//============================================================
	// Counters
	//============================================================

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			cycle_count <= '0;
			ms_count    <= '0;
			prescale    <= '0;
		end
		else
		begin
			cycle_count <= cycle_count + 1'b1;
			if (prescale == PRE_LAST)
			begin
				prescale <= '0;
				ms_count <= ms_count + 1'b1;
			end
			else
				prescale <= prescale + 1'b1;
		end
	end

	//============================================================
	// Read port, writes fall on the floor
	//============================================================

	always_comb
	begin
		case (bus.address[3:2])
			2'd0:    bus.rdata = cycle_count;
			2'd1:    bus.rdata = ms_count;
			default: bus.rdata = '0;
		endcase
	end

	assign bus.ready = bus.request;

endmodule

// File: source/soc_bus.sv
`timescale 1ns/1ps

module soc_bus
	import soc_pkg::*;
#(
	parameter int RAM_WORDS    = 16384,
	parameter int TICKS_PER_MS = 100000
)
(
	input  logic      clock,
	input  logic      i_reset,

	// Port A, instruction fetch
	input  logic      i_pa_request,
	input  bus_addr_t i_pa_address,
	output bus_data_t o_pa_rdata,
	output logic      o_pa_ready,

	// Port B, data
	input  logic      i_pb_request,
	input  logic      i_pb_rw,
	input  bus_addr_t i_pb_address,
	input  bus_data_t i_pb_wdata,
	output bus_data_t o_pb_rdata,
	output logic      o_pb_ready,

	output led_t      o_ledr
);

	// Shared bus and one branch per target
	soc_bus_if bus ();
	soc_bus_if ram_bus ();
	soc_bus_if led_bus ();
	soc_bus_if timer_bus ();

	//============================================================
	// Input side
	//============================================================

	bus_arbiter u_arbiter (
		.clock        (clock),
		.i_reset      (i_reset),
		.i_pa_request (i_pa_request),
		.i_pa_address (i_pa_address),
		.o_pa_rdata   (o_pa_rdata),
		.o_pa_ready   (o_pa_ready),
		.i_pb_request (i_pb_request),
		.i_pb_rw      (i_pb_rw),
		.i_pb_address (i_pb_address),
		.i_pb_wdata   (i_pb_wdata),
		.o_pb_rdata   (o_pb_rdata),
		.o_pb_ready   (o_pb_ready),
		.bus          (bus)
	);

	bus_decoder u_decoder (
		.bus       (bus),
		.ram_bus   (ram_bus),
		.led_bus   (led_bus),
		.timer_bus (timer_bus)
	);

	//============================================================
	// Targets
	//============================================================

	block_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clock (clock),
		.bus   (ram_bus)
	);

	led_register u_led (
		.clock   (clock),
		.i_reset (i_reset),
		.bus     (led_bus),
		.o_ledr  (o_ledr)
	);

	cycle_timer #(
		.TICKS_PER_MS (TICKS_PER_MS)
	) u_timer (
		.clock   (clock),
		.i_reset (i_reset),
		.bus     (timer_bus)
	);

endmodule

// File: verif/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus
	import soc_pkg::*;
();

	localparam int TICKS_PER_MS = 10;
	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 16;
	localparam int N_PAIRS      = 4;
	localparam int N_WORDS      = 16;
	localparam int N_RANDOM     = 16;
	// Transfers per section in test order
	localparam int N_TRANSFERS  = 2 * N_PAIRS + N_WORDS + N_RANDOM + 2 * N_WORDS + 2 + 4 + 4;
	localparam int WATCHDOG_NS  = (N_TRANSFERS * 20 + RESET_CYCLES) * 2 * HALF_PERIOD;
	localparam bus_addr_t UNMAPPED = 32'h3000_0000;
	localparam bus_addr_t TIMER_MS = TIMER_BASE + 32'd4;

	logic      clock;
	logic      i_reset;
	logic      i_pa_request;
	bus_addr_t i_pa_address;
	bus_data_t o_pa_rdata;
	logic      o_pa_ready;
	logic      i_pb_request;
	logic      i_pb_rw;
	bus_addr_t i_pb_address;
	bus_data_t i_pb_wdata;
	bus_data_t o_pb_rdata;
	logic      o_pb_ready;
	led_t      o_ledr;

	// Reference model state
	bus_data_t shadow_ram [bus_addr_t];
	led_t      shadow_led;

	// Reads waiting for the comparing process
	string     name_q [$];
	bus_data_t exp_q [$];
	bus_data_t act_q [$];

	bit        grant_log [$];
	int        pa_issued;
	int        pb_issued;
	int        pa_pulses;
	int        pb_pulses;
	int        value_errors;
	int        other_errors;
	integer    seed;

	soc_bus #(
		.TICKS_PER_MS (TICKS_PER_MS)
	) u_dut (
		.clock        (clock),
		.i_reset      (i_reset),
		.i_pa_request (i_pa_request),
		.i_pa_address (i_pa_address),
		.o_pa_rdata   (o_pa_rdata),
		.o_pa_ready   (o_pa_ready),
		.i_pb_request (i_pb_request),
		.i_pb_rw      (i_pb_rw),
		.i_pb_address (i_pb_address),
		.i_pb_wdata   (i_pb_wdata),
		.o_pb_rdata   (o_pb_rdata),
		.o_pb_ready   (o_pb_ready),
		.o_ledr       (o_ledr)
	);

	always #(HALF_PERIOD) clock = ~clock;

	//============================================================
	// Reference model and checks
	//============================================================

	function automatic bus_data_t expected_read(input bus_addr_t address);
		if (address >= RAM_BASE && address < RAM_LIMIT)
		begin
			if (shadow_ram.exists(address))
				return shadow_ram[address];
			return '0;
		end
		if (address >= LED_BASE && address < LED_LIMIT)
			return bus_data_t'(shadow_led);
		// Unmapped space reads as zero
		return '0;
	endfunction

	function automatic bus_addr_t ram_word(input int idx);
		// Spread across the RAM window
		return RAM_BASE + bus_addr_t'(idx) * 32'h0000_0ff4;
	endfunction

	task automatic check_data(input string name, input bus_data_t expected,
		input bus_data_t actual);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_led(input string name, input led_t expected, input led_t actual);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("Failure: %s", what);
	endtask

	task automatic queue_read(input string name, input bus_addr_t address, input bus_data_t data);
		name_q.push_back(name);
		exp_q.push_back(expected_read(address));
		act_q.push_back(data);
	endtask

	// Reads queued on falling edges are compared on the next rising edge
	always @(posedge clock)
	begin
		while (exp_q.size() > 0)
			check_data(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
	end

	// Ready pulses logged in arrival order with 1 for port B
	always @(negedge clock)
	begin
		if (o_pa_ready)
		begin
			pa_pulses++;
			grant_log.push_back(1'b0);
		end
		if (o_pb_ready)
		begin
			pb_pulses++;
			grant_log.push_back(1'b1);
		end
	end

	//============================================================
	// Master drivers
	//============================================================

	task automatic pa_read(input bus_addr_t address, output bus_data_t data);
		@(negedge clock);
		i_pa_request = 1'b1;
		i_pa_address = address;
		pa_issued++;
		do
			@(negedge clock);
		while (!o_pa_ready);
		data = o_pa_rdata;
		i_pa_request = 1'b0;
	endtask

	task automatic pb_read(input bus_addr_t address, output bus_data_t data);
		@(negedge clock);
		i_pb_request = 1'b1;
		i_pb_rw      = 1'b0;
		i_pb_address = address;
		pb_issued++;
		do
			@(negedge clock);
		while (!o_pb_ready);
		data = o_pb_rdata;
		i_pb_request = 1'b0;
	endtask

	task automatic pb_write(input bus_addr_t address, input bus_data_t data);
		@(negedge clock);
		i_pb_request = 1'b1;
		i_pb_rw      = 1'b1;
		i_pb_address = address;
		i_pb_wdata   = data;
		pb_issued++;
		do
			@(negedge clock);
		while (!o_pb_ready);
		i_pb_request = 1'b0;
		i_pb_rw      = 1'b0;
		// Model follows the memory map
		if (address >= RAM_BASE && address < RAM_LIMIT)
			shadow_ram[address] = data;
		else if (address >= LED_BASE && address < LED_LIMIT)
			shadow_led = data[9:0];
	endtask

	//============================================================
	// Test sequence
	//============================================================

	initial
	begin
		bus_data_t da;
		bus_data_t db;
		bus_data_t wd;
		bus_data_t c0;
		bus_data_t c1;
		bus_data_t ms;
		int        idx;

		seed         = 32'ha9b1_875d;
		clock        = 1'b0;
		i_reset      = 1'b1;
		i_pa_request = 1'b0;
		i_pa_address = '0;
		i_pb_request = 1'b0;
		i_pb_rw      = 1'b0;
		i_pb_address = '0;
		i_pb_wdata   = '0;
		shadow_led   = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		i_reset = 1'b0;

		check_led("reset ledr", '0, o_ledr);
		if (o_pa_ready || o_pb_ready)
			report_failure("a port ready is high right after reset");

		// Both ports at once right after reset so port B wins the first tie
		grant_log.delete();
		for (int p = 0; p < N_PAIRS; p++)
		begin
			wd = bus_data_t'($random(seed));
			fork
				begin
					pa_read(LED_BASE, da);
					queue_read("concurrent led read", LED_BASE, da);
				end
				pb_write(LED_BASE, wd);
			join
			check_led("concurrent led write", wd[9:0], o_ledr);
		end
		// Last pulse is logged on the falling edge just passed
		@(posedge clock);
		if (grant_log.size() != 2 * N_PAIRS)
			report_failure("wrong number of ready pulses in concurrent test");
		else
			for (int i = 0; i < 2 * N_PAIRS; i++)
				if (grant_log[i] != ((i % 2) == 0))
					report_failure("grants do not alternate starting with port B");

		// RAM fill, random overwrites, then reads through both ports
		for (idx = 0; idx < N_WORDS; idx++)
			pb_write(ram_word(idx), bus_data_t'($random(seed)));
		for (int n = 0; n < N_RANDOM; n++)
		begin
			idx = $unsigned($random(seed)) % N_WORDS;
			pb_write(ram_word(idx), bus_data_t'($random(seed)));
		end
		for (idx = 0; idx < N_WORDS; idx++)
		begin
			pa_read(ram_word(idx), da);
			queue_read("ram read port a", ram_word(idx), da);
			pb_read(ram_word(idx), db);
			queue_read("ram read port b", ram_word(idx), db);
		end

		// LED write and read back
		wd = bus_data_t'($random(seed));
		pb_write(LED_BASE, wd);
		check_led("led write", wd[9:0], o_ledr);
		pb_read(LED_BASE, db);
		queue_read("led read", LED_BASE, db);

		// Unmapped space answers with zero and ignores writes
		pa_read(UNMAPPED, da);
		queue_read("unmapped read", UNMAPPED, da);
		pb_write(UNMAPPED, 32'hffff_ffff);
		check_led("led after unmapped write", shadow_led, o_ledr);
		pb_read(LED_BASE, db);
		queue_read("led read after unmapped write", LED_BASE, db);
		pa_read(ram_word(0), da);
		queue_read("ram read after unmapped write", ram_word(0), da);

		// Timer
		pb_read(TIMER_BASE, c0);
		pa_read(TIMER_BASE, c1);
		if (!(c1 > c0))
			report_failure("timer cycle count did not increase between reads");
		pb_read(TIMER_BASE, c0);
		pb_read(TIMER_MS, ms);
		if (ms < c0 / TICKS_PER_MS || ms > (c0 + 20) / TICKS_PER_MS)
			report_failure("timer millisecond count does not match the cycle count");

		// Let the comparing process drain
		@(posedge clock);
		@(negedge clock);
		check_data("port a ready pulses", bus_data_t'(pa_issued), bus_data_t'(pa_pulses));
		check_data("port b ready pulses", bus_data_t'(pb_issued), bus_data_t'(pb_pulses));
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: files.f
source/soc_pkg.sv
source/soc_bus_if.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/block_ram.sv
source/led_register.sv
source/cycle_timer.sv
source/soc_bus.sv
verif/tb_soc_bus.sv

// File: run.sh
#!/bin/sh
# Compile and run the soc_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_soc_bus -f files.f \
	-Mdir obj_dir -o tb_soc_bus > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/tb_soc_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
exit 0
